/* fetch_consts.svh */
/*
 * Fetch front end constants
 * Word width, reset vector, local memory map and queue depth
 */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Address and instruction width
`define FETCH_XLEN 32

// First PC after reset, inside local memory
`define FETCH_RESET_VEC 32'h0000_1080

////////////////////////////////////////
// Local instruction memory
`define IMEM_BASE 32'h0000_1000
`define IMEM_WORDS 256
`define IMEM_ADDR_W 8

////////////////////////////////////////
// Fetches in flight
`define FETCH_QUEUE_DEPTH 2

`endif

/* mem_map_pkg.sv */
/*
 * Memory map of the fetch front end
 * Region encoding and the address range check
 */
`include "fetch_consts.svh"

package mem_map_pkg;

    // Target of a fetch address
    typedef enum logic {
        region_local_mem,
        region_none
    } region_t;

    ////////////////////////////////////////
    // Range check against the local memory window
    function automatic region_t region_of(input logic [`FETCH_XLEN-1:0] addr);
        logic [`FETCH_XLEN-1:0] offset;
        offset = addr - `IMEM_BASE;
        if (addr >= `IMEM_BASE && offset < (`IMEM_WORDS * 4)) begin
            return region_local_mem;
        end
        // Anything else is an access fault
        return region_none;
    endfunction

endpackage

/* fetch_pkg.sv */
/*
 * Fetch pipeline types
 * PC source select, fetch status and the queued fetch attributes
 */
`include "fetch_consts.svh"

package fetch_pkg;

    // Next PC source
    typedef enum logic [1:0] {
        pc_reset,
        pc_redirect,
        pc_increment
    } pc_src_t;

    // Result of one fetch
    typedef enum logic {
        fetch_ok,
        fetch_access_fault
    } fetch_status_t;

    ////////////////////////////////////////
    // Per fetch attributes, kept in order until completion
    typedef struct packed {
        logic [`FETCH_XLEN-1:0] pc;
        fetch_status_t status;
        mem_map_pkg::region_t region;
    } fetch_attr_t;

endpackage

/* imem_bus_if.sv */
/*
 * Instruction memory bus
 * Single-cycle request strobe, data returns one cycle later
 */
`timescale 1ns/1ns
`include "fetch_consts.svh"

interface imem_bus_if;

    // Request side
    logic new_request;
    logic [`FETCH_XLEN-1:0] addr;

    // Response side, no back-pressure
    logic data_valid;
    logic [`FETCH_XLEN-1:0] data_out;

    modport issuer (
        output new_request,
        output addr,
        input data_valid,
        input data_out
    );

    modport memory (
        input new_request,
        input addr,
        output data_valid,
        output data_out
    );

endinterface

/* fetch_issue.sv */
/*
 * Fetch issue
 * Holds the PC, picks the next PC and issues fetch requests
 */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_issue (
    input logic clk,
    input logic rst,
    input logic hold,
    input logic redirect,
    input logic [`FETCH_XLEN-1:0] redirect_pc,
    input logic queue_full,
    output logic push,
    output fetch_pkg::fetch_attr_t push_attr,
    imem_bus_if.issuer bus
);
    import fetch_pkg::*;
    import mem_map_pkg::*;

    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] next_pc;
    pc_src_t pc_src;
    region_t region;
    logic issue_en;
    logic issue;

    ////////////////////////////////////////
    // Issue control

    // Keeps requests off until the cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_en <= 1'b0;
        end else begin
            issue_en <= 1'b1;
        end
    end

    assign issue = issue_en & ~hold & ~redirect & ~queue_full;

    ////////////////////////////////////////
    // Program counter
    always_comb begin
        if (rst) begin
            pc_src = pc_reset;
        end else if (redirect) begin
            pc_src = pc_redirect;
        end else begin
            pc_src = pc_increment;
        end
    end

    always_comb begin
        case (pc_src)
            pc_reset: next_pc = `FETCH_RESET_VEC;
            pc_redirect: next_pc = redirect_pc;
            default: next_pc = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst | redirect | issue) begin
            pc <= next_pc;
        end
    end

    ////////////////////////////////////////
    // Request and attribute
    assign region = region_of(pc);

    assign push = issue;
    assign push_attr.pc = pc;
    assign push_attr.status = (region == region_none) ? fetch_access_fault : fetch_ok;
    assign push_attr.region = region;

    // Faulting fetches never reach the memory
    assign bus.new_request = issue & (region == region_local_mem);
    assign bus.addr = pc;

    pc_aligned_a: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("Fetch PC lost word alignment");

endmodule

/* fetch_attr_fifo.sv */
/*
 * Fetch attribute queue
 * Circular buffer that returns fetch attributes in issue order
 */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_attr_fifo #(
    parameter int DEPTH = `FETCH_QUEUE_DEPTH
) (
    input logic clk,
    input logic rst,
    input logic push,
    input fetch_pkg::fetch_attr_t push_attr,
    input logic pop,
    output logic full,
    output logic head_valid,
    output fetch_pkg::fetch_attr_t head_attr
);
    import fetch_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_attr_t entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    ////////////////////////////////////////
    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_attr;
        end
    end

    ////////////////////////////////////////
    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign full = (count == CNT_W'(DEPTH));
    assign head_valid = (count != '0);
    assign head_attr = entries[rd_ptr];

    // Issue must stall on full and completion must wait for an entry
    no_push_full_a: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("Push into full attribute queue");

    no_pop_empty_a: assert property (@(posedge clk) disable iff (rst) pop |-> head_valid)
        else $error("Pop from empty attribute queue");

endmodule

/* local_imem_unit.sv */
/*
 * Local instruction memory
 * Word array with a load port and one-cycle read latency
 */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module local_imem_unit (
    input logic clk,
    input logic rst,
    input logic load_en,
    input logic [`IMEM_ADDR_W-1:0] load_addr,
    input logic [`FETCH_XLEN-1:0] load_data,
    imem_bus_if.memory bus
);

    logic [`FETCH_XLEN-1:0] mem [`IMEM_WORDS];
    logic [`FETCH_XLEN-1:0] offset;
    logic [`IMEM_ADDR_W-1:0] rd_index;

    // Byte offset into the memory window and its word index
    assign offset = bus.addr - `IMEM_BASE;
    assign rd_index = offset[`IMEM_ADDR_W+1:2];

    ////////////////////////////////////////
    // Load port
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    ////////////////////////////////////////
    // Read path
    always_ff @(posedge clk) begin
        if (bus.new_request) begin
            bus.data_out <= mem[rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.data_valid <= 1'b0;
        end else begin
            bus.data_valid <= bus.new_request;
        end
    end

    // Word index keeps only the low offset bits
    req_in_window_a: assert property (@(posedge clk) disable iff (rst)
        bus.new_request |-> (offset < (`IMEM_WORDS * 4)))
        else $error("Instruction memory request outside the local window");

endmodule

/* fetch_response.sv */
/*
 * Fetch response
 * Completes fetches in order and drops those made stale by a redirect
 */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_response (
    input logic clk,
    input logic rst,
    input logic redirect,
    input logic push,
    input logic head_valid,
    input fetch_pkg::fetch_attr_t head_attr,
    input logic data_valid,
    input logic [`FETCH_XLEN-1:0] data_out,
    output logic pop,
    output logic fetch_complete,
    output logic [`FETCH_XLEN-1:0] fetch_pc,
    output logic [`FETCH_XLEN-1:0] fetch_instruction,
    output logic fetch_fault
);
    import fetch_pkg::*;
    import mem_map_pkg::*;

    localparam int CNT_W = $clog2(`FETCH_QUEUE_DEPTH + 1);

    logic [CNT_W-1:0] inflight_count;
    logic [CNT_W-1:0] inflight_next;
    logic [CNT_W-1:0] flush_count;
    logic head_fault;
    logic complete;

    ////////////////////////////////////////
    // Completion
    assign head_fault = (head_attr.status == fetch_access_fault);

    // Faults complete as soon as they reach the head
    assign complete = head_valid & (head_fault | data_valid);
    assign pop = complete;

    assign fetch_complete = complete & (flush_count == '0);
    assign fetch_pc = head_attr.pc;
    assign fetch_instruction = data_out;
    assign fetch_fault = head_fault;

    ////////////////////////////////////////
    // In-flight and flush tracking
    assign inflight_next = inflight_count + CNT_W'(push) - CNT_W'(pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_count <= '0;
        end else begin
            inflight_count <= inflight_next;
        end
    end

    // Everything still in flight after a redirect gets discarded
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_count <= '0;
        end else if (redirect) begin
            flush_count <= inflight_next;
        end else if (pop && flush_count != '0) begin
            flush_count <= flush_count - 1'b1;
        end
    end

    // Memory data must belong to an in-range fetch at the head
    data_has_head_a: assert property (@(posedge clk) disable iff (rst)
        data_valid |-> (head_valid && head_attr.region == region_local_mem))
        else $error("Instruction data with no matching fetch at queue head");

    flush_bounded_a: assert property (@(posedge clk) disable iff (rst)
        flush_count <= inflight_count)
        else $error("Flush count above in-flight count");

endmodule

/* fetch_unit.sv */
/*
 * Instruction fetch front end
 * Connects issue, attribute queue, local memory and response logic
 */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_unit (
    input logic clk,
    input logic rst,
    input logic hold,
    input logic redirect,
    input logic [`FETCH_XLEN-1:0] redirect_pc,
    input logic load_en,
    input logic [`IMEM_ADDR_W-1:0] load_addr,
    input logic [`FETCH_XLEN-1:0] load_data,
    output logic fetch_complete,
    output logic [`FETCH_XLEN-1:0] fetch_pc,
    output logic [`FETCH_XLEN-1:0] fetch_instruction,
    output logic fetch_fault
);
    import fetch_pkg::*;

    logic queue_full;
    logic push;
    fetch_attr_t push_attr;
    logic pop;
    logic head_valid;
    fetch_attr_t head_attr;

    imem_bus_if bus ();

    fetch_issue u_issue (
        .clk (clk),
        .rst (rst),
        .hold (hold),
        .redirect (redirect),
        .redirect_pc (redirect_pc),
        .queue_full (queue_full),
        .push (push),
        .push_attr (push_attr),
        .bus (bus.issuer)
    );

    fetch_attr_fifo #(
        .DEPTH (`FETCH_QUEUE_DEPTH)
    ) u_attr_fifo (
        .clk (clk),
        .rst (rst),
        .push (push),
        .push_attr (push_attr),
        .pop (pop),
        .full (queue_full),
        .head_valid (head_valid),
        .head_attr (head_attr)
    );

    local_imem_unit u_imem (
        .clk (clk),
        .rst (rst),
        .load_en (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .bus (bus.memory)
    );

    fetch_response u_response (
        .clk (clk),
        .rst (rst),
        .redirect (redirect),
        .push (push),
        .head_valid (head_valid),
        .head_attr (head_attr),
        .data_valid (bus.data_valid),
        .data_out (bus.data_out),
        .pop (pop),
        .fetch_complete (fetch_complete),
        .fetch_pc (fetch_pc),
        .fetch_instruction (fetch_instruction),
        .fetch_fault (fetch_fault)
    );

endmodule

/* tb_fetch.sv */
/*
 * Fetch front end testbench
 * Loads the instruction memory, then runs free fetch, redirect and hold phases
 */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module tb_fetch;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 3;
    localparam int FREE_CYCLES = 40;
    localparam int REDIRECT_CYCLES = 150;
    localparam int HOLD_ROUNDS = 12;
    localparam int ROUND_MAX = 14;
    localparam int RUN_CYCLES = RESET_CYCLES + `IMEM_WORDS + FREE_CYCLES + REDIRECT_CYCLES
        + HOLD_ROUNDS * ROUND_MAX + 10;
    localparam int TIMEOUT_NS = (RUN_CYCLES + 50) * CLK_PERIOD;

    logic clk;
    logic rst;
    logic hold;
    logic redirect;
    logic [`FETCH_XLEN-1:0] redirect_pc;
    logic load_en;
    logic [`IMEM_ADDR_W-1:0] load_addr;
    logic [`FETCH_XLEN-1:0] load_data;
    logic fetch_complete;
    logic [`FETCH_XLEN-1:0] fetch_pc;
    logic [`FETCH_XLEN-1:0] fetch_instruction;
    logic fetch_fault;

    ////////////////////////////////////////
    // Reference model state
    integer seed = 94096;
    logic [31:0] mem_model [`IMEM_WORDS];
    logic [31:0] model_pc = `FETCH_RESET_VEC;
    logic [31:0] exp_pc = '0;
    logic [31:0] exp_instr = '0;
    logic exp_fault = 1'b0;
    logic quiet = 1'b0;
    int hold_age = 0;
    int hold_completions = 0;
    logic hold_ok = 1'b1;
    logic resume_pending = 1'b0;
    int resume_wait = 0;
    int completions = 0;
    int fault_completions = 0;

    int pc_errors = 0;
    int instr_errors = 0;
    int fault_errors = 0;
    int quiet_errors = 0;
    int hold_errors = 0;
    int other_errors = 0;

    fetch_unit uut (
        .clk (clk),
        .rst (rst),
        .hold (hold),
        .redirect (redirect),
        .redirect_pc (redirect_pc),
        .load_en (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .fetch_complete (fetch_complete),
        .fetch_pc (fetch_pc),
        .fetch_instruction (fetch_instruction),
        .fetch_fault (fetch_fault)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Model helpers
    function automatic logic in_local_range(input logic [31:0] addr);
        logic [31:0] upper;
        upper = `IMEM_BASE + `IMEM_WORDS * 4;
        return (addr >= `IMEM_BASE) && (addr < upper);
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - `IMEM_BASE;
        return mem_model[offset[`IMEM_ADDR_W+1:2]];
    endfunction

    // Mix of in-range targets and ones that cross the window edges
    function automatic logic [31:0] random_target();
        logic [31:0] pick;
        logic [31:0] word;
        pick = $unsigned($random(seed)) % 5;
        word = $unsigned($random(seed)) % `IMEM_WORDS;
        case (pick)
            0: return `IMEM_BASE - 32'd8;
            1: return `IMEM_BASE + `IMEM_WORDS * 4 - 8;
            2: return 32'h8000_0000 + (word << 2);
            default: return `IMEM_BASE + (word << 2);
        endcase
    endfunction

    // Outputs seen this cycle, against the PC sequence and the hold window
    task automatic observe_outputs();
        if (fetch_complete) begin
            exp_pc = model_pc;
            exp_fault = !in_local_range(model_pc);
            exp_instr = exp_fault ? '0 : model_word(model_pc);
            model_pc = model_pc + 32'd4;
            completions++;
            if (exp_fault) begin
                fault_completions++;
            end
        end
        if (hold) begin
            hold_age++;
            if (fetch_complete) begin
                hold_completions++;
            end
        end else begin
            if (hold_age > 0) begin
                resume_pending = 1'b1;
                resume_wait = 0;
            end
            hold_age = 0;
            hold_completions = 0;
        end
        if (fetch_complete) begin
            resume_pending = 1'b0;
        end else if (resume_pending) begin
            resume_wait++;
        end
        hold_ok = (hold_age == 0) ||
            (hold_age <= 2 && hold_completions <= `FETCH_QUEUE_DEPTH);
    endtask

    task automatic next_cycle();
        @(negedge clk);
        observe_outputs();
        redirect = 1'b0;
        load_en = 1'b0;
    endtask

    task automatic send_redirect(input logic [31:0] target);
        redirect = 1'b1;
        redirect_pc = target;
        model_pc = target;
    endtask

    ////////////////////////////////////////
    // Stimulus phases
    task automatic load_memory();
        logic [31:0] word;
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            next_cycle();
            word = $random(seed);
            load_en = 1'b1;
            load_addr = i[`IMEM_ADDR_W-1:0];
            load_data = word;
            mem_model[i] = word;
        end
        next_cycle();
    endtask

    task automatic run_free(input int cycles);
        repeat (cycles) next_cycle();
    endtask

    task automatic run_redirects(input int cycles);
        repeat (cycles) begin
            next_cycle();
            if (($unsigned($random(seed)) % 6) == 0) begin
                send_redirect(random_target());
            end
        end
    endtask

    task automatic run_holds(input int rounds);
        int free_len;
        int hold_len;
        next_cycle();
        send_redirect(`IMEM_BASE);
        repeat (rounds) begin
            free_len = 3 + ($unsigned($random(seed)) % 6);
            hold_len = 3 + ($unsigned($random(seed)) % 4);
            run_free(free_len);
            hold = 1'b1;
            run_free(hold_len);
            hold = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // Checks, sampled on the rising edge
    pc_check_a: assert property (@(posedge clk) fetch_complete |-> fetch_pc == exp_pc)
        else begin
            pc_errors++;
            $display("CHECK FAILED t=%0t fetch_pc got %h expected %h",
                $time, $sampled(fetch_pc), $sampled(exp_pc));
        end

    instr_check_a: assert property (@(posedge clk)
        fetch_complete && !fetch_fault |-> fetch_instruction == exp_instr)
        else begin
            instr_errors++;
            $display("CHECK FAILED t=%0t fetch_instruction got %h expected %h",
                $time, $sampled(fetch_instruction), $sampled(exp_instr));
        end

    fault_check_a: assert property (@(posedge clk) fetch_complete |-> fetch_fault == exp_fault)
        else begin
            fault_errors++;
            $display("CHECK FAILED t=%0t fetch_fault got %b expected %b",
                $time, $sampled(fetch_fault), $sampled(exp_fault));
        end

    // No completion through reset and memory load
    quiet_check_a: assert property (@(posedge clk) quiet |-> !fetch_complete)
        else begin
            quiet_errors++;
            $display("CHECK FAILED t=%0t fetch_complete got 1 expected 0", $time);
        end

    hold_check_a: assert property (@(posedge clk) fetch_complete |-> hold_ok)
        else begin
            hold_errors++;
            $display("Completion at t=%0t came too late or too often during hold", $time);
        end

    resume_check_a: assert property (@(posedge clk) resume_pending |-> resume_wait <= 2)
        else begin
            hold_errors++;
            $display("Fetching did not resume after hold was released, t=%0t", $time);
        end

    ////////////////////////////////////////
    // Main sequence
    initial begin
        int total;
        rst = 1'b1;
        hold = 1'b1;
        redirect = 1'b0;
        redirect_pc = '0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;

        next_cycle();
        quiet = 1'b1;
        repeat (RESET_CYCLES - 1) next_cycle();
        rst = 1'b0;

        load_memory();
        quiet = 1'b0;
        hold = 1'b0;

        run_free(FREE_CYCLES);
        run_redirects(REDIRECT_CYCLES);
        run_holds(HOLD_ROUNDS);
        run_free(2);
        @(posedge clk);
        #1;

        if (completions < FREE_CYCLES) begin
            other_errors++;
            $display("Too few fetches completed: %0d", completions);
        end
        if (fault_completions == 0) begin
            other_errors++;
            $display("No access fault completion was seen");
        end
        total = pc_errors + instr_errors + fault_errors + quiet_errors + hold_errors
            + other_errors;
        $display("Errors: pc=%0d instruction=%0d fault=%0d reset=%0d hold=%0d other=%0d",
            pc_errors, instr_errors, fault_errors, quiet_errors, hold_errors, other_errors);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog timeout after %0d ns, the test sequence did not finish", TIMEOUT_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* project.f */
+incdir+.
mem_map_pkg.sv
fetch_pkg.sv
imem_bus_if.sv
fetch_issue.sv
fetch_attr_fifo.sv
local_imem_unit.sv
fetch_response.sv
fetch_unit.sv
tb_fetch.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ns --top-module tb_fetch \
    -f project.f -o tb_fetch_sim

status=0
./obj_dir/tb_fetch_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
exit 1
